// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  // beat geometry.
  localparam int data_bytes = 4;
  localparam int data_width = data_bytes * 8;

  // width of the frame length limit and of the beat counter.
  localparam int len_width = 16;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [data_bytes-1:0] keep;
    logic                  last;
    logic                  user; // bad frame flag after the checker, read with last.
  } beat_t;

  // one-cycle pulses, one per finished frame.
  typedef struct packed {
    logic good;
    logic bad;
    logic overflow;
  } frame_status_t;

endpackage

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  localparam int axil_addr_width = 4;
  localparam int axil_data_width = 32;

  typedef logic [axil_data_width-1:0] csr_word_t;

  localparam logic [15:0] max_len_reset = 16'd64;

  typedef enum logic [axil_addr_width-1:0] {
    reg_max_len  = 4'h0,
    reg_good_cnt = 4'h4,
    reg_bad_cnt  = 4'h8,
    reg_ovf_cnt  = 4'hc
  } csr_addr_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  typedef struct packed {
    logic                       awvalid;
    logic [axil_addr_width-1:0] awaddr;
    logic                       wvalid;
    csr_word_t                  wdata;
    logic                       bready;
    logic                       arvalid;
    logic [axil_addr_width-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    resp_e     bresp;
    logic      arready;
    logic      rvalid;
    csr_word_t rdata;
    resp_e     rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== frame_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_check (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire stream_pkg::beat_t              s_beat,
  input  wire                                 s_valid,
  output logic                                s_ready,
  output stream_pkg::beat_t                   chk_beat,
  output logic                                chk_valid,
  input  wire                                 chk_ready,
  input  wire [stream_pkg::len_width-1:0]     max_len
);

  logic [stream_pkg::len_width-1:0] beat_cnt_q;  // beats of this frame already taken.
  logic [stream_pkg::len_width-1:0] frame_max_q;
  logic [stream_pkg::len_width-1:0] limit;
  logic                             err_q;
  logic                             too_long;
  logic                             frame_err;
  logic                             take;
  stream_pkg::beat_t                out_beat;

  assign s_ready = !chk_valid || chk_ready;
  assign take = s_valid && s_ready;

  // the limit is sampled with the first beat and held for the frame.
  assign limit = (beat_cnt_q == '0) ? max_len : frame_max_q;
  assign too_long = beat_cnt_q >= limit;
  assign frame_err = err_q || s_beat.user || too_long;

  always_comb begin
    out_beat = s_beat;
    out_beat.user = s_beat.last && frame_err; // only the last beat carries the verdict.
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid  <= 1'b0;
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
    end else begin
      if (take) begin
        chk_valid <= 1'b1;
        if (s_beat.last) begin
          beat_cnt_q <= '0;
          err_q      <= 1'b0;
        end else begin
          if (beat_cnt_q != '1) begin
            beat_cnt_q <= beat_cnt_q + (stream_pkg::len_width)'(1);  // saturates on huge frames.
          end
          err_q <= frame_err;
        end
      end else if (chk_ready) begin
        chk_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      chk_beat <= out_beat;
      if (beat_cnt_q == '0) begin
        frame_max_q <= max_len;
      end
    end
  end

endmodule

`default_nettype wire

// ==== frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
  parameter int fifo_addr_width = 10
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire stream_pkg::beat_t         chk_beat,
  input  wire                            chk_valid,
  output logic                           chk_ready,
  output stream_pkg::beat_t              m_beat,
  output logic                           m_valid,
  input  wire                            m_ready,
  output stream_pkg::frame_status_t      status
);

  localparam int depth = 2 ** fifo_addr_width;

  typedef logic [fifo_addr_width:0] ptr_t;

  stream_pkg::beat_t mem [depth];

  ptr_t wr_ptr_q;     // committed frames end here.
  ptr_t wr_ptr_d;
  ptr_t wr_cur_q;     // speculative, frame in progress.
  ptr_t wr_cur_d;
  ptr_t wr_commit_q;  // committed pointer as seen by the read side.
  ptr_t rd_ptr_q;

  logic                      drop_q;
  logic                      drop_d;
  stream_pkg::frame_status_t status_d;
  logic                      accept;
  logic                      write;
  logic                      read;
  logic                      store_output;
  logic                      full_cur;
  logic                      empty;

  stream_pkg::beat_t mem_rd_q;
  logic              mem_rd_valid_q;
  logic              mem_rd_valid_d;

  // never stalls. frames that do not fit are dropped instead.
  assign chk_ready = 1'b1;
  assign accept = chk_valid && chk_ready;

  assign full_cur = (wr_cur_q[fifo_addr_width] != rd_ptr_q[fifo_addr_width]) &&
                    (wr_cur_q[fifo_addr_width-1:0] == rd_ptr_q[fifo_addr_width-1:0]);
  assign empty = wr_commit_q == rd_ptr_q;

  always_comb begin
    write    = 1'b0;
    drop_d   = drop_q;
    status_d = '0;
    wr_ptr_d = wr_ptr_q;
    wr_cur_d = wr_cur_q;
    if (accept) begin
      if (full_cur || drop_q) begin
        drop_d = 1'b1;
        if (chk_beat.last) begin
          drop_d            = 1'b0;
          wr_cur_d          = wr_ptr_q;  // rewind.
          status_d.overflow = 1'b1;
        end
      end else begin
        write    = 1'b1;
        wr_cur_d = wr_cur_q + ptr_t'(1);
        if (chk_beat.last) begin
          if (chk_beat.user) begin
            wr_cur_d     = wr_ptr_q;
            status_d.bad = 1'b1;
          end else begin
            wr_ptr_d      = wr_cur_q + ptr_t'(1);
            status_d.good = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q    <= '0;
      wr_cur_q    <= '0;
      wr_commit_q <= '0;
      drop_q      <= 1'b0;
      status      <= '0;
    end else begin
      wr_ptr_q    <= wr_ptr_d;
      wr_cur_q    <= wr_cur_d;
      wr_commit_q <= wr_ptr_q;
      drop_q      <= drop_d;
      status      <= status_d;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_cur_q[fifo_addr_width-1:0]] <= chk_beat;
    end
  end

  // read stage and output register, two beats in flight at most.
  assign store_output = m_ready || !m_valid;

  always_comb begin
    read           = 1'b0;
    mem_rd_valid_d = mem_rd_valid_q;
    if (store_output || !mem_rd_valid_q) begin
      if (!empty) begin
        read           = 1'b1;
        mem_rd_valid_d = 1'b1;
      end else begin
        mem_rd_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q       <= '0;
      mem_rd_valid_q <= 1'b0;
      m_valid        <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      mem_rd_valid_q <= mem_rd_valid_d;
      if (store_output) begin
        m_valid <= mem_rd_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_q <= mem[rd_ptr_q[fifo_addr_width-1:0]];
    end
    if (store_output) begin
      m_beat <= mem_rd_q;
    end
  end

endmodule

`default_nettype wire

// ==== frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  wire                             clk,
  input  wire                             rst,
  input  wire stream_pkg::frame_status_t  status,
  input  wire csr_pkg::axil_req_t         axil_req,
  output csr_pkg::axil_rsp_t              axil_rsp,
  output logic [stream_pkg::len_width-1:0] max_len
);

  logic [2:0][csr_pkg::axil_data_width-1:0] cnt_q;  // good, bad, overflow.
  logic [2:0] hit;
  logic [2:0] clr;
  logic       wr_hs;
  logic       rd_hs;
  logic       max_len_we;
  logic       bvalid_q;
  logic       rvalid_q;

  csr_pkg::resp_e    wr_resp;
  csr_pkg::resp_e    rd_resp;
  csr_pkg::resp_e    bresp_q;
  csr_pkg::resp_e    rresp_q;
  csr_pkg::csr_word_t rd_word;
  csr_pkg::csr_word_t rdata_q;

  assign hit = {status.overflow, status.bad, status.good};
  assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_hs = axil_req.arvalid && !rvalid_q;

  // write decode. a write to a count clears it.
  always_comb begin
    clr        = '0;
    max_len_we = 1'b0;
    wr_resp    = csr_pkg::resp_okay;
    case (csr_pkg::csr_addr_e'(axil_req.awaddr))
      csr_pkg::reg_max_len:  max_len_we = wr_hs;
      csr_pkg::reg_good_cnt: clr[0] = wr_hs;
      csr_pkg::reg_bad_cnt:  clr[1] = wr_hs;
      csr_pkg::reg_ovf_cnt:  clr[2] = wr_hs;
      default:               wr_resp = csr_pkg::resp_slverr;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_resp = csr_pkg::resp_okay;
    case (csr_pkg::csr_addr_e'(axil_req.araddr))
      csr_pkg::reg_max_len:  rd_word = csr_pkg::csr_word_t'(max_len);
      csr_pkg::reg_good_cnt: rd_word = cnt_q[0];
      csr_pkg::reg_bad_cnt:  rd_word = cnt_q[1];
      csr_pkg::reg_ovf_cnt:  rd_word = cnt_q[2];
      default:               rd_resp = csr_pkg::resp_slverr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q    <= '0;
      max_len  <= csr_pkg::max_len_reset;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clr[i]) begin
          cnt_q[i] <= '0;
        end else if (hit[i] && cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + csr_pkg::csr_word_t'(1);  // saturating.
        end
      end
      if (max_len_we) begin
        max_len <= axil_req.wdata[stream_pkg::len_width-1:0];
      end
      if (wr_hs) bvalid_q <= 1'b1;
      else if (axil_req.bready) bvalid_q <= 1'b0;
      if (rd_hs) rvalid_q <= 1'b1;
      else if (axil_req.rready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp_q <= wr_resp;
    end
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_hs;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

// ==== frame_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top #(
  parameter int fifo_addr_width = 10
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire stream_pkg::beat_t   s_beat,
  input  wire                      s_valid,
  output logic                     s_ready,
  output stream_pkg::beat_t        m_beat,
  output logic                     m_valid,
  input  wire                      m_ready,
  input  wire csr_pkg::axil_req_t  axil_req,
  output csr_pkg::axil_rsp_t       axil_rsp
);

  stream_pkg::beat_t                chk_beat;
  logic                             chk_valid;
  logic                             chk_ready;
  stream_pkg::frame_status_t        status;
  logic [stream_pkg::len_width-1:0] max_len;

  // marks bad frames on their last beat.
  frame_check check0 (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (s_beat),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .chk_beat  (chk_beat),
    .chk_valid (chk_valid),
    .chk_ready (chk_ready),
    .max_len   (max_len)
  );

  frame_fifo #(
    .fifo_addr_width (fifo_addr_width)
  ) fifo0 (
    .clk       (clk),
    .rst       (rst),
    .chk_beat  (chk_beat),
    .chk_valid (chk_valid),
    .chk_ready (chk_ready),
    .m_beat    (m_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .status    (status)
  );

  frame_stats stats0 (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .max_len  (max_len)  // limit used by the checker.
  );

endmodule

`default_nettype wire

// ==== frame_buffer_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_chk (
  input wire                            clk,
  input wire                            rst,
  input wire stream_pkg::beat_t         m_beat,
  input wire                            m_valid,
  input wire                            m_ready,
  input wire stream_pkg::frame_status_t status,
  input wire csr_pkg::axil_req_t        axil_req,
  input wire csr_pkg::axil_rsp_t        axil_rsp
);

  int stall_fails = 0;
  int pulse_fails = 0;
  int rd_fails = 0;
  int wr_fails = 0;
  int reset_fails = 0;
  int fails;

  assign fails = stall_fails + pulse_fails + rd_fails + wr_fails + reset_fails;

  m_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else begin
      stall_fails++;
      $error("output beat changed while m_ready was low");
    end

  pulse_excl: assert property (@(posedge clk) disable iff (rst) $onehot0(status))
    else begin
      pulse_fails++;
      $error("more than one status pulse in a cycle");
    end

  r_hold: assert property (@(posedge clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
      rd_fails++;
      $error("read data dropped or changed before rready");
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      wr_fails++;
      $error("write response dropped before bready");
    end

  rst_quiet: assert property (@(posedge clk) rst |=> !m_valid && status == '0)
    else begin
      reset_fails++;
      $error("m_valid or a status pulse high during reset");
    end

endmodule

bind frame_buffer_top frame_buffer_chk chk0 (
  .clk      (clk),
  .rst      (rst),
  .m_beat   (m_beat),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .status   (status),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

`default_nettype wire

// ==== tb_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_buffer;

  localparam int depth = 16;         // fifo_addr_width of 4.
  localparam int wait_cycles = 2000;

  logic               clk;
  logic               rst;
  stream_pkg::beat_t  s_beat;
  logic               s_valid;
  logic               s_ready;
  stream_pkg::beat_t  m_beat;
  logic               m_valid;
  logic               m_ready = 1'b0;
  csr_pkg::axil_req_t axil_req;
  csr_pkg::axil_rsp_t axil_rsp;

  stream_pkg::beat_t         exp_q[$];      // beats of the frames that must come out.
  stream_pkg::frame_status_t verdict_q[$];
  stream_pkg::beat_t         rx_beat;
  stream_pkg::frame_status_t rx_verdict;
  logic [31:0] data_seed = 32'h490f_1924;
  logic [31:0] rdy_seed = 32'h490f_1924;
  int rdy_mode = 1;                         // 0 low, 1 high, 2 random.
  int len_limit = 64;
  int exp_good = 0;
  int exp_bad = 0;
  int exp_ovf = 0;
  int errs = 0;
  int rx_errs = 0;
  int tests = 0;
  int failed = 0;
  int errs_at_start = 0;
  int sent = 0;
  int seen = 0;

  frame_buffer_top #(
    .fifo_addr_width (4)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .s_beat   (s_beat),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk) begin
    rdy_seed <= lcg(rdy_seed);
    m_ready  <= (rdy_mode == 2) ? rdy_seed[16] : (rdy_mode == 1);
  end

  // output beats and status pulses against the expected queues.
  always @(posedge clk) begin
    if (!rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: a beat came out while no frame was expected", $time);
        rx_errs++;
      end else begin
        rx_beat = exp_q.pop_front();
        assert (m_beat == rx_beat) else begin
          $display("Error at %0t: m_beat got %h expected %h", $time, m_beat, rx_beat);
          rx_errs++;
        end
      end
    end
    if (!rst && dut0.status != '0) begin
      seen++;
      rx_verdict = (verdict_q.size() != 0) ? verdict_q.pop_front() : '0;
      assert (dut0.status == rx_verdict) else begin
        $display("Error at %0t: status got %b expected %b", $time, dut0.status, rx_verdict);
        rx_errs++;
      end
    end
  end

  task automatic stop_run(input string what);
    errs++;
    $display("%s", what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic send_frame(input int len, input int bad_at);
    stream_pkg::beat_t         b;
    stream_pkg::frame_status_t v;
    int t;
    v = '0;
    if (exp_q.size() + len > depth) begin
      v.overflow = 1'b1;
      exp_ovf++;
    end else if (bad_at >= 0 || len > len_limit) begin
      v.bad = 1'b1;
      exp_bad++;
    end else begin
      v.good = 1'b1;
      exp_good++;
    end
    verdict_q.push_back(v);
    @(posedge clk);
    for (int i = 0; i < len; i++) begin
      data_seed = lcg(data_seed);
      b.data    = data_seed;
      b.keep    = 4'hf;
      b.last    = (i == len - 1);
      b.user    = (i == bad_at);
      s_beat  <= b;
      s_valid <= 1'b1;
      if (v.good) exp_q.push_back(b);
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!s_ready && t < wait_cycles);
      if (!s_ready) stop_run("timeout waiting for s_ready");
    end
    s_valid <= 1'b0;
    sent++;
  endtask

  task automatic wait_space(input int len);
    int t;
    t = 0;
    while (exp_q.size() + len > depth && t < wait_cycles) begin
      @(posedge clk);
      t++;
    end
    if (exp_q.size() + len > depth) stop_run("timeout waiting for room in the frame FIFO");
  endtask

  task automatic wait_done(input bit drain);
    int t;
    t = 0;
    while ((seen != sent || (drain && exp_q.size() != 0)) && t < wait_cycles) begin
      @(posedge clk);
      t++;
    end
    if (seen != sent || (drain && exp_q.size() != 0)) begin
      stop_run("timeout waiting for frames to finish");
    end
  endtask

  task automatic csr_write(input logic [3:0] addr, input logic [31:0] data);
    int             t;
    csr_pkg::resp_e resp;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!(axil_rsp.awready && axil_rsp.wready) && t < wait_cycles);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(posedge clk);
    axil_req.bready <= 1'b1;  // a cycle late, so bvalid has to hold.
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.bvalid && t < wait_cycles);
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
    if (t >= wait_cycles) begin
      stop_run("timeout on an AXI4-Lite write");
    end else begin
      assert (resp == csr_pkg::resp_okay) else begin
        $display("Error at %0t: bresp got %0d expected %0d", $time, resp, csr_pkg::resp_okay);
        errs++;
      end
    end
  endtask

  task automatic csr_read(input logic [3:0] addr, output logic [31:0] data,
                          output csr_pkg::resp_e resp);
    int t;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.arready && t < wait_cycles);
    axil_req.arvalid <= 1'b0;
    @(posedge clk);
    axil_req.rready <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.rvalid && t < wait_cycles);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
    if (t >= wait_cycles) stop_run("timeout on an AXI4-Lite read");
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected,
                           input string name);
    logic [31:0]    got;
    csr_pkg::resp_e resp;
    csr_read(addr, got, resp);
    assert (resp == csr_pkg::resp_okay && got == expected) else begin
      $display("Error at %0t: %s got %0d (resp %0d) expected %0d", $time, name, got, resp,
               expected);
      errs++;
    end
  endtask

  task automatic end_test(input string name);
    int now_errs;
    now_errs = errs + rx_errs + dut0.chk0.fails;
    tests++;
    if (now_errs == errs_at_start) begin
      $display("test %0d, %s: pass", tests, name);
    end else begin
      $display("test %0d, %s: fail", tests, name);
      failed++;
    end
    errs_at_start = now_errs;
  endtask

  initial begin
    int             n;
    logic [31:0]    word;
    csr_pkg::resp_e resp;
    rst      = 1'b1;
    s_valid  = 1'b0;
    s_beat   = '0;
    axil_req = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int len = 1; len <= 8; len++) begin
      wait_space(len);
      send_frame(len, -1);
    end
    wait_done(1'b1);
    check_reg(csr_pkg::reg_good_cnt, exp_good, "good count");
    end_test("good frames in order");

    wait_space(5);
    send_frame(5, 2);  // user on a middle beat.
    wait_space(3);
    send_frame(3, -1);
    wait_done(1'b1);
    check_reg(csr_pkg::reg_bad_cnt, exp_bad, "bad count");
    end_test("user error drop");

    csr_write(csr_pkg::reg_max_len, 6);
    len_limit = 6;
    check_reg(csr_pkg::reg_max_len, 6, "max_len");
    wait_space(7);
    send_frame(7, -1);
    wait_space(6);
    send_frame(6, -1);
    wait_done(1'b1);
    check_reg(csr_pkg::reg_bad_cnt, exp_bad, "bad count");
    check_reg(csr_pkg::reg_good_cnt, exp_good, "good count");
    csr_write(csr_pkg::reg_max_len, 64);
    len_limit = 64;
    end_test("max length");

    // 8 + 8 fills the 16 beats and leaves no room for the 3-beat frame.
    rdy_mode = 0;
    send_frame(8, -1);
    send_frame(8, -1);
    send_frame(3, -1);
    wait_done(1'b0);
    check_reg(csr_pkg::reg_ovf_cnt, exp_ovf, "overflow count");
    rdy_mode = 1;
    wait_done(1'b1);
    end_test("overflow with m_ready low");

    rdy_mode = 2;
    repeat (12) begin
      data_seed = lcg(data_seed);
      n = 1 + int'(data_seed[10:8]);
      wait_space(n);
      send_frame(n, -1);
    end
    wait_done(1'b1);
    rdy_mode = 1;
    check_reg(csr_pkg::reg_good_cnt, exp_good, "good count");
    end_test("random back-pressure");

    csr_write(csr_pkg::reg_good_cnt, 0);
    csr_write(csr_pkg::reg_bad_cnt, 0);
    csr_write(csr_pkg::reg_ovf_cnt, 0);
    exp_good = 0;
    exp_bad  = 0;
    exp_ovf  = 0;
    check_reg(csr_pkg::reg_good_cnt, exp_good, "good count");
    check_reg(csr_pkg::reg_bad_cnt, exp_bad, "bad count");
    check_reg(csr_pkg::reg_ovf_cnt, exp_ovf, "overflow count");
    csr_read(4'h2, word, resp);
    assert (resp == csr_pkg::resp_slverr) else begin
      $display("Error at %0t: rresp got %0d expected %0d", $time, resp, csr_pkg::resp_slverr);
      errs++;
    end
    end_test("count clear and unmapped read");

    $display("tests: %0d run, %0d passed, %0d failed", tests, tests - failed, failed);
    if (failed == 0 && errs + rx_errs + dut0.chk0.fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
stream_pkg.sv
csr_pkg.sv
frame_check.sv
frame_fifo.sv
frame_stats.sv
frame_buffer_top.sv
frame_buffer_chk.sv
tb_frame_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frame_buffer
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
